// ==== xm_bus_pkg.sv ====
// host bus package: register numbers, byte and word types, synchronized bus operation
package xm_bus_pkg;

    localparam int SYNC_STAGES = 2;                 // flops per synchronizer chain

    typedef logic [7:0]  byte_t;                    // one host data byte
    typedef logic [15:0] word_t;                    // one register word

    // host visible register numbers
    typedef enum logic [3:0] {
        XM_SYS_CTRL,                                // nibble mask, status bits
        XM_INT_CTRL,                                // interrupt mask, clear, status
        XM_TIMER,                                   // 1/10 ms timer, read only
        XM_RD_XADDR,                                // XR read address
        XM_WR_XADDR,                                // XR write address
        XM_XDATA,                                   // XR data port
        XM_RD_INCR,                                 // VRAM read increment
        XM_RD_ADDR,                                 // VRAM read address
        XM_WR_INCR,                                 // VRAM write increment
        XM_WR_ADDR,                                 // VRAM write address
        XM_DATA,                                    // VRAM data port
        XM_DATA_2,                                  // second VRAM data port
        XM_UNUSED_0C,
        XM_UNUSED_0D,
        XM_UNUSED_0E,
        XM_UNUSED_0F
    } reg_num_t;

    // one operation after synchronization
    typedef struct packed {
        logic     wr_stb;                           // one cycle write strobe
        logic     rd_stb;                           // one cycle read strobe
        reg_num_t reg_num;                          // held until next op
        logic     bytesel;                          // 1 = odd (low) byte
        byte_t    data;                             // written byte
    } bus_op_t;

    // even byte is the high byte, odd byte the low byte
    function automatic word_t set_byte(word_t w, logic odd, byte_t b);
        return odd ? {w[15:8], b} : {b, w[7:0]};
    endfunction

endpackage

// ==== xm_mem_pkg.sv ====
// memory side package: address, mask, interrupt and request types plus timer constants
package xm_mem_pkg;

    localparam int PCLK_HZ = 25125000;              // fixed 640x480 pixel clock

    // 10 kHz / PCLK_HZ reduced to 2 / 5025
    localparam int TIMER_HZ_REDUCED  = 2;
    localparam int TIMER_CLK_REDUCED = PCLK_HZ * TIMER_HZ_REDUCED / 10000;
    localparam int TIMER_FRAC_BITS   = $clog2(TIMER_CLK_REDUCED) + 1;    // sign bit on top

    typedef logic [15:0] addr_t;                    // VRAM or XR word address
    typedef logic [3:0]  wrmask_t;                  // VRAM nibble write enables
    typedef logic [6:0]  intr_t;                    // interrupt vector
    typedef logic [TIMER_FRAC_BITS-1:0] timer_frac_t;

    localparam wrmask_t WRMASK_RESET = '1;          // all nibbles writable

    // request to VRAM or XR, sel held until ack
    typedef struct packed {
        logic        sel;                           // request pending
        logic        wr;                            // 1 = write, 0 = read
        addr_t       addr;
        logic [15:0] data;                          // write data
    } mem_req_t;

endpackage

// ==== xm_bus_sync.sv ====
// host bus synchronizer, one strobed bus operation per chip select falling edge
module xm_bus_sync (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                bus_cs_n_i,         // async chip select
    input  logic                bus_rd_nwr_i,       // 1 = read
    input  logic                bus_bytesel_i,      // 1 = odd byte
    input  logic [3:0]          bus_reg_num_i,
    input  xm_bus_pkg::byte_t   bus_data_i,
    output xm_bus_pkg::bus_op_t bus_op_o
);

    // pins that travel next to chip select
    typedef struct packed {
        logic                 rd_nwr;
        xm_bus_pkg::reg_num_t reg_num;
        logic                 bytesel;
        xm_bus_pkg::byte_t    data;
    } pins_t;

    logic  [xm_bus_pkg::SYNC_STAGES-1:0] cs_n_sync;    // cs chain, [0] nearest the pin
    pins_t [xm_bus_pkg::SYNC_STAGES-1:0] pin_sync;     // matching chain for the other pins
    pins_t pins_now;                                    // raw pins
    pins_t pins_last;                                   // synchronized pins
    logic  cs_n_last;                                   // edge register
    logic  cs_fall;

    always_comb begin
        pins_now.rd_nwr  = bus_rd_nwr_i;
        pins_now.reg_num = xm_bus_pkg::reg_num_t'(bus_reg_num_i);
        pins_now.bytesel = bus_bytesel_i;
        pins_now.data    = bus_data_i;
    end

    assign pins_last = pin_sync[xm_bus_pkg::SYNC_STAGES-1];
    assign cs_fall   = cs_n_last & ~cs_n_sync[xm_bus_pkg::SYNC_STAGES-1];   // high to low

    always_ff @(posedge clk) begin
        pin_sync <= {pin_sync[xm_bus_pkg::SYNC_STAGES-2:0], pins_now};
        if (cs_fall) begin                              // latch until next op
            bus_op_o.reg_num <= pins_last.reg_num;
            bus_op_o.bytesel <= pins_last.bytesel;
            bus_op_o.data    <= pins_last.data;
        end
        if (reset_i) begin
            cs_n_sync       <= '1;                      // idle, no false edge
            cs_n_last       <= 1'b1;
            bus_op_o.wr_stb <= 1'b0;
            bus_op_o.rd_stb <= 1'b0;
        end else begin
            cs_n_sync       <= {cs_n_sync[xm_bus_pkg::SYNC_STAGES-2:0], bus_cs_n_i};
            cs_n_last       <= cs_n_sync[xm_bus_pkg::SYNC_STAGES-1];
            bus_op_o.wr_stb <= cs_fall & ~pins_last.rd_nwr;    // 3 clocks after pin edge
            bus_op_o.rd_stb <= cs_fall & pins_last.rd_nwr;
        end
    end

endmodule

// ==== xm_vram_port.sv ====
// VRAM port: address and increment registers, data staging, read-ahead and write requests
module xm_vram_port (
    input  logic                 clk,
    input  logic                 reset_i,
    input  xm_bus_pkg::bus_op_t  bus_op_i,
    input  logic                 vram_ack_i,        // one cycle, ends the request
    input  xm_bus_pkg::word_t    vram_data_i,
    output xm_mem_pkg::mem_req_t vram_req_o,
    output logic                 busy_o,
    output xm_bus_pkg::word_t    rd_incr_o,
    output xm_bus_pkg::word_t    rd_addr_o,
    output xm_bus_pkg::word_t    wr_incr_o,
    output xm_bus_pkg::word_t    wr_addr_o,
    output xm_bus_pkg::word_t    data_o             // last word read
);

    xm_bus_pkg::byte_t data_even;                   // staged high byte of a data write
    logic              odd;
    logic              data_reg;                    // DATA or DATA_2 addressed

    assign busy_o   = vram_req_o.sel;
    assign odd      = bus_op_i.bytesel;
    assign data_reg = (bus_op_i.reg_num == xm_bus_pkg::XM_DATA) ||
                      (bus_op_i.reg_num == xm_bus_pkg::XM_DATA_2);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_req_o <= '0;
            rd_incr_o  <= '0;
            rd_addr_o  <= '0;
            wr_incr_o  <= '0;
            wr_addr_o  <= '0;
        end else begin
            if (vram_req_o.sel && vram_ack_i) begin
                vram_req_o.sel <= 1'b0;
                vram_req_o.wr  <= 1'b0;
                if (vram_req_o.wr) begin
                    wr_addr_o <= wr_addr_o + wr_incr_o;     // next write slot
                end else begin
                    data_o    <= vram_data_i;               // read-ahead result
                    rd_addr_o <= rd_addr_o + rd_incr_o;
                end
            end
            if (bus_op_i.wr_stb) begin
                case (bus_op_i.reg_num)
                    xm_bus_pkg::XM_RD_INCR:
                        rd_incr_o <= xm_bus_pkg::set_byte(rd_incr_o, odd, bus_op_i.data);
                    xm_bus_pkg::XM_RD_ADDR: begin
                        rd_addr_o <= xm_bus_pkg::set_byte(rd_addr_o, odd, bus_op_i.data);
                        if (odd) begin                      // new address, read it at once
                            vram_req_o.sel  <= 1'b1;
                            vram_req_o.wr   <= 1'b0;
                            vram_req_o.addr <= {rd_addr_o[15:8], bus_op_i.data};
                        end
                    end
                    xm_bus_pkg::XM_WR_INCR:
                        wr_incr_o <= xm_bus_pkg::set_byte(wr_incr_o, odd, bus_op_i.data);
                    xm_bus_pkg::XM_WR_ADDR:
                        wr_addr_o <= xm_bus_pkg::set_byte(wr_addr_o, odd, bus_op_i.data);
                    default: ;
                endcase
                if (data_reg && !odd) begin
                    data_even <= bus_op_i.data;             // wait for low byte
                end else if (data_reg) begin
                    vram_req_o.sel  <= 1'b1;                // full word, write it
                    vram_req_o.wr   <= 1'b1;
                    vram_req_o.addr <= wr_addr_o;
                    vram_req_o.data <= {data_even, bus_op_i.data};
                end
            end
            if (bus_op_i.rd_stb && odd && data_reg) begin
                vram_req_o.sel  <= 1'b1;                    // fetch next word ahead
                vram_req_o.wr   <= 1'b0;
                vram_req_o.addr <= rd_addr_o;
            end
        end
    end

endmodule

// ==== xm_xr_port.sv ====
// XR port: read and write address registers with fixed +1 advance, staging and read-ahead
module xm_xr_port (
    input  logic                 clk,
    input  logic                 reset_i,
    input  xm_bus_pkg::bus_op_t  bus_op_i,
    input  logic                 xr_ack_i,          // one cycle, ends the request
    input  xm_bus_pkg::word_t    xr_data_i,
    output xm_mem_pkg::mem_req_t xr_req_o,
    output logic                 busy_o,
    output xm_bus_pkg::word_t    rd_xaddr_o,
    output xm_bus_pkg::word_t    wr_xaddr_o,
    output xm_bus_pkg::word_t    xdata_o            // last XR word read
);

    xm_bus_pkg::byte_t xdata_even;                  // staged high byte
    logic              odd;
    logic              xdata_reg;

    assign busy_o    = xr_req_o.sel;
    assign odd       = bus_op_i.bytesel;
    assign xdata_reg = (bus_op_i.reg_num == xm_bus_pkg::XM_XDATA);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            xr_req_o   <= '0;
            rd_xaddr_o <= '0;
            wr_xaddr_o <= '0;
        end else begin
            if (xr_req_o.sel && xr_ack_i) begin
                xr_req_o.sel <= 1'b0;
                xr_req_o.wr  <= 1'b0;
                if (xr_req_o.wr) begin
                    wr_xaddr_o <= wr_xaddr_o + 16'd1;       // always +1
                end else begin
                    xdata_o    <= xr_data_i;
                    rd_xaddr_o <= rd_xaddr_o + 16'd1;
                end
            end
            if (bus_op_i.wr_stb) begin
                case (bus_op_i.reg_num)
                    xm_bus_pkg::XM_RD_XADDR: begin
                        rd_xaddr_o <= xm_bus_pkg::set_byte(rd_xaddr_o, odd, bus_op_i.data);
                        if (odd) begin                      // start XR read at new address
                            xr_req_o.sel  <= 1'b1;
                            xr_req_o.wr   <= 1'b0;
                            xr_req_o.addr <= {rd_xaddr_o[15:8], bus_op_i.data};
                        end
                    end
                    xm_bus_pkg::XM_WR_XADDR:
                        wr_xaddr_o <= xm_bus_pkg::set_byte(wr_xaddr_o, odd, bus_op_i.data);
                    xm_bus_pkg::XM_XDATA: begin
                        if (!odd) begin
                            xdata_even <= bus_op_i.data;
                        end else begin
                            xr_req_o.sel  <= 1'b1;          // word complete
                            xr_req_o.wr   <= 1'b1;
                            xr_req_o.addr <= wr_xaddr_o;
                            xr_req_o.data <= {xdata_even, bus_op_i.data};
                        end
                    end
                    default: ;
                endcase
            end
            if (bus_op_i.rd_stb && odd && xdata_reg) begin
                xr_req_o.sel  <= 1'b1;                      // read-ahead
                xr_req_o.wr   <= 1'b0;
                xr_req_o.addr <= rd_xaddr_o;
            end
        end
    end

endmodule

// ==== xm_timer.sv ====
// free running 1/10 ms timer from a fractional divider of the pixel clock
module xm_timer (
    input  logic              clk,
    input  logic              reset_i,
    output xm_bus_pkg::word_t timer_o               // wraps at 16 bits
);

    xm_mem_pkg::timer_frac_t frac;                  // signed accumulator
    logic                    tick;

    assign tick = ~frac[xm_mem_pkg::TIMER_FRAC_BITS-1];    // non-negative, time to count

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac    <= '0;
            timer_o <= '0;
        end else if (tick) begin
            frac    <= frac + xm_mem_pkg::timer_frac_t'(xm_mem_pkg::TIMER_HZ_REDUCED -
                                                        xm_mem_pkg::TIMER_CLK_REDUCED);
            timer_o <= timer_o + 16'd1;
        end else begin
            frac    <= frac + xm_mem_pkg::timer_frac_t'(xm_mem_pkg::TIMER_HZ_REDUCED);
        end
    end

endmodule

// ==== xm_sys_regs.sv ====
// system registers: nibble mask, interrupt control, timer latch and host readback mux
module xm_sys_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  xm_bus_pkg::bus_op_t bus_op_i,
    input  xm_bus_pkg::word_t   rd_incr_i,
    input  xm_bus_pkg::word_t   rd_addr_i,
    input  xm_bus_pkg::word_t   wr_incr_i,
    input  xm_bus_pkg::word_t   wr_addr_i,
    input  xm_bus_pkg::word_t   data_i,
    input  xm_bus_pkg::word_t   rd_xaddr_i,
    input  xm_bus_pkg::word_t   wr_xaddr_i,
    input  xm_bus_pkg::word_t   xdata_i,
    input  xm_bus_pkg::word_t   timer_i,
    input  logic                vram_busy_i,
    input  logic                xr_busy_i,
    input  logic                h_blank_i,
    input  logic                v_blank_i,
    input  xm_mem_pkg::intr_t   intr_status_i,
    output xm_mem_pkg::wrmask_t vram_wrmask_o,
    output xm_mem_pkg::intr_t   intr_mask_o,
    output xm_mem_pkg::intr_t   intr_clear_o,       // one cycle pulse
    output xm_bus_pkg::byte_t   bus_data_o
);

    xm_bus_pkg::byte_t timer_lo;                    // low byte frozen at high byte read
    xm_bus_pkg::word_t rd_word;

    always_ff @(posedge clk) begin
        if (bus_op_i.rd_stb && !bus_op_i.bytesel) begin
            timer_lo <= timer_i[7:0];               // any even read
        end
        if (reset_i) begin
            vram_wrmask_o <= xm_mem_pkg::WRMASK_RESET;
            intr_mask_o   <= '0;
            intr_clear_o  <= '0;
        end else begin
            intr_clear_o <= '0;
            if (bus_op_i.wr_stb && bus_op_i.reg_num == xm_bus_pkg::XM_SYS_CTRL &&
                bus_op_i.bytesel) begin
                vram_wrmask_o <= bus_op_i.data[3:0];
            end
            if (bus_op_i.wr_stb && bus_op_i.reg_num == xm_bus_pkg::XM_INT_CTRL) begin
                if (bus_op_i.bytesel) begin
                    intr_clear_o <= bus_op_i.data[6:0];     // ack pending interrupts
                end else begin
                    intr_mask_o  <= bus_op_i.data[6:0];
                end
            end
        end
    end

    // readback, valid while chip select is still low
    always_comb begin
        case (bus_op_i.reg_num)
            xm_bus_pkg::XM_SYS_CTRL:
                rd_word = {vram_busy_i | xr_busy_i, 3'b000, h_blank_i, v_blank_i, 6'b0,
                           vram_wrmask_o};          // blitter bits read as zero
            xm_bus_pkg::XM_INT_CTRL: rd_word = {1'b0, intr_mask_o, 1'b0, intr_status_i};
            xm_bus_pkg::XM_TIMER:    rd_word = {timer_i[15:8], timer_lo};
            xm_bus_pkg::XM_RD_XADDR: rd_word = rd_xaddr_i;
            xm_bus_pkg::XM_WR_XADDR: rd_word = wr_xaddr_i;
            xm_bus_pkg::XM_XDATA:    rd_word = xdata_i;
            xm_bus_pkg::XM_RD_INCR:  rd_word = rd_incr_i;
            xm_bus_pkg::XM_RD_ADDR:  rd_word = rd_addr_i;
            xm_bus_pkg::XM_WR_INCR:  rd_word = wr_incr_i;
            xm_bus_pkg::XM_WR_ADDR:  rd_word = wr_addr_i;
            default:                 rd_word = data_i;      // DATA, DATA_2, 0C to 0F
        endcase
        bus_data_o = bus_op_i.bytesel ? rd_word[7:0] : rd_word[15:8];
    end

endmodule

// ==== xm_reg_interface.sv ====
// host register interface top: bus synchronizer, VRAM and XR ports, timer and system registers
module xm_reg_interface (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 bus_cs_n_i,
    input  logic                 bus_rd_nwr_i,
    input  logic [3:0]           bus_reg_num_i,
    input  logic                 bus_bytesel_i,
    input  xm_bus_pkg::byte_t    bus_data_i,
    output xm_bus_pkg::byte_t    bus_data_o,
    output xm_mem_pkg::mem_req_t vram_req_o,
    input  logic                 vram_ack_i,
    input  xm_bus_pkg::word_t    vram_data_i,
    output xm_mem_pkg::mem_req_t xr_req_o,
    input  logic                 xr_ack_i,
    input  xm_bus_pkg::word_t    xr_data_i,
    input  logic                 h_blank_i,
    input  logic                 v_blank_i,
    input  xm_mem_pkg::intr_t    intr_status_i,
    output xm_mem_pkg::wrmask_t  vram_wrmask_o,
    output xm_mem_pkg::intr_t    intr_mask_o,
    output xm_mem_pkg::intr_t    intr_clear_o
);

    xm_bus_pkg::bus_op_t bus_op;                    // broadcast to all register stages
    xm_bus_pkg::word_t   rd_incr, rd_addr, wr_incr, wr_addr, data;
    xm_bus_pkg::word_t   rd_xaddr, wr_xaddr, xdata, timer;
    logic                vram_busy, xr_busy;

    xm_bus_sync xm_bus_sync_i (
        .clk, .reset_i, .bus_cs_n_i, .bus_rd_nwr_i, .bus_bytesel_i, .bus_reg_num_i,
        .bus_data_i, .bus_op_o(bus_op)
    );

    xm_vram_port xm_vram_port_i (
        .clk, .reset_i, .bus_op_i(bus_op), .vram_ack_i, .vram_data_i, .vram_req_o,
        .busy_o(vram_busy), .rd_incr_o(rd_incr), .rd_addr_o(rd_addr),
        .wr_incr_o(wr_incr), .wr_addr_o(wr_addr), .data_o(data)
    );

    xm_xr_port xm_xr_port_i (
        .clk, .reset_i, .bus_op_i(bus_op), .xr_ack_i, .xr_data_i, .xr_req_o,
        .busy_o(xr_busy), .rd_xaddr_o(rd_xaddr), .wr_xaddr_o(wr_xaddr), .xdata_o(xdata)
    );

    xm_timer xm_timer_i (
        .clk, .reset_i, .timer_o(timer)
    );

    xm_sys_regs xm_sys_regs_i (
        .clk, .reset_i, .bus_op_i(bus_op),
        .rd_incr_i(rd_incr), .rd_addr_i(rd_addr), .wr_incr_i(wr_incr),
        .wr_addr_i(wr_addr), .data_i(data), .rd_xaddr_i(rd_xaddr),
        .wr_xaddr_i(wr_xaddr), .xdata_i(xdata), .timer_i(timer),
        .vram_busy_i(vram_busy), .xr_busy_i(xr_busy), .h_blank_i, .v_blank_i,
        .intr_status_i, .vram_wrmask_o, .intr_mask_o, .intr_clear_o, .bus_data_o
    );

endmodule

// ==== tb_xm_sva.sv ====
// protocol checker for the register interface, bound to the top level ports
module xm_reg_interface_sva (
    input logic                 clk,
    input logic                 reset_i,
    input xm_mem_pkg::mem_req_t vram_req_o,
    input logic                 vram_ack_i,
    input xm_mem_pkg::mem_req_t xr_req_o,
    input logic                 xr_ack_i,
    input xm_mem_pkg::intr_t    intr_clear_o,
    input xm_mem_pkg::wrmask_t  vram_wrmask_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // request stays up until the memory answers
    vram_sel_held: assert property (@(posedge clk) disable iff (reset_i)
        vram_req_o.sel && !vram_ack_i |=> vram_req_o.sel)
        else $error("VRAM request dropped before its ack");

    xr_sel_held: assert property (@(posedge clk) disable iff (reset_i)
        xr_req_o.sel && !xr_ack_i |=> xr_req_o.sel)
        else $error("XR request dropped before its ack");

    // wr only meaningful with sel
    vram_wr_needs_sel: assert property (@(posedge clk) disable iff (reset_i)
        !(vram_req_o.wr && !vram_req_o.sel))
        else $error("VRAM wr high without sel");

    xr_wr_needs_sel: assert property (@(posedge clk) disable iff (reset_i)
        !(xr_req_o.wr && !xr_req_o.sel))
        else $error("XR wr high without sel");

    // clear is a single cycle pulse
    clear_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        intr_clear_o != '0 |=> intr_clear_o == '0)
        else $error("interrupt clear held longer than one cycle");

    // idle state right after reset
    reset_state: assert property (@(posedge clk)
        reset_i |=> !vram_req_o.sel && !xr_req_o.sel && vram_wrmask_o == '1)
        else $error("wrong request or mask state after reset");

endmodule

bind xm_reg_interface xm_reg_interface_sva xm_reg_interface_sva_i (
    .clk, .reset_i, .vram_req_o, .vram_ack_i, .xr_req_o, .xr_ack_i,
    .intr_clear_o, .vram_wrmask_o
);

// ==== tb_xm_reg_interface.sv ====
// testbench for the host register interface: host bus tasks, memory models, directed tests
module tb_xm_reg_interface;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        logic [15:0] data;
        logic [3:0]  mask;
    } mem_rec_t;                                    // one served memory request

    logic clk = 1'b0;
    logic reset;
    logic bus_cs_n, bus_rd_nwr, bus_bytesel;
    logic [3:0] bus_reg_num;
    logic [7:0] bus_data, bus_data_o;
    xm_mem_pkg::mem_req_t vram_req, xr_req;
    logic vram_ack, xr_ack, h_blank, v_blank;
    logic [15:0] vram_data, xr_data;
    logic [6:0] intr_status, intr_mask, intr_clear, clear_value;
    logic [3:0] wrmask;
    mem_rec_t vram_log[$];
    mem_rec_t xr_log[$];
    int cycle = 0;
    int clear_count = 0;

    xm_reg_interface xm_reg_interface_i (
        .clk, .reset_i(reset), .bus_cs_n_i(bus_cs_n), .bus_rd_nwr_i(bus_rd_nwr),
        .bus_reg_num_i(bus_reg_num), .bus_bytesel_i(bus_bytesel), .bus_data_i(bus_data),
        .bus_data_o, .vram_req_o(vram_req), .vram_ack_i(vram_ack), .vram_data_i(vram_data),
        .xr_req_o(xr_req), .xr_ack_i(xr_ack), .xr_data_i(xr_data), .h_blank_i(h_blank),
        .v_blank_i(v_blank), .intr_status_i(intr_status), .vram_wrmask_o(wrmask),
        .intr_mask_o(intr_mask), .intr_clear_o(intr_clear)
    );

    always #50 clk = ~clk;                          // 100 ns period

    always @(posedge clk) cycle <= cycle + 1;

    always @(negedge clk) begin                     // away from the update edge
        if (intr_clear != '0) begin
            clear_count = clear_count + 1;
            clear_value = intr_clear;
        end
    end

    // memory contents seen by both models
    function automatic logic [15:0] model_word(input logic [15:0] addr);
        return addr ^ 16'ha5c3;
    endfunction

    initial begin : vram_model
        int d;
        forever begin
            @(posedge clk);
            #5;
            if (vram_req.sel) begin
                d = $urandom_range(4, 1);           // variable latency
                repeat (d) @(posedge clk);
                #5;
                vram_ack = 1'b1;
                vram_data = model_word(vram_req.addr);
                vram_log.push_back({vram_req.wr, vram_req.addr, vram_req.data, wrmask});
                @(posedge clk);
                #5;
                vram_ack = 1'b0;
            end
        end
    end

    initial begin : xr_model
        int d;
        forever begin
            @(posedge clk);
            #5;
            if (xr_req.sel) begin
                d = $urandom_range(4, 1);
                repeat (d) @(posedge clk);
                #5;
                xr_ack = 1'b1;
                xr_data = model_word(xr_req.addr);
                xr_log.push_back({xr_req.wr, xr_req.addr, xr_req.data, 4'h0});
                @(posedge clk);
                #5;
                xr_ack = 1'b0;
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp) else begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // one byte access, cs low for 6 cycles, read data sampled before release
    task automatic host_access(input logic rd, input logic [3:0] regn, input logic odd,
                               input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge clk);
        #5;
        bus_rd_nwr = rd;
        bus_reg_num = regn;
        bus_bytesel = odd;
        bus_data = wdata;
        bus_cs_n = 1'b0;
        repeat (4) @(posedge clk);
        #5;
        rdata = bus_data_o;                         // before any read-ahead lands
        repeat (2) @(posedge clk);
        #5;
        bus_cs_n = 1'b1;
        repeat (3) @(posedge clk);                  // let the synchronizer see cs high
        #5;
    endtask

    task automatic write_byte(input logic [3:0] regn, input logic odd, input logic [7:0] b);
        logic [7:0] unused;
        host_access(1'b0, regn, odd, b, unused);
    endtask

    task automatic write_word(input logic [3:0] regn, input logic [15:0] w);
        write_byte(regn, 1'b0, w[15:8]);
        write_byte(regn, 1'b1, w[7:0]);
    endtask

    task automatic read_word(input logic [3:0] regn, output logic [15:0] w);
        host_access(1'b1, regn, 1'b0, 8'h00, w[15:8]);
        host_access(1'b1, regn, 1'b1, 8'h00, w[7:0]);
    endtask

    // poll the busy bit in SYS_CTRL
    task automatic wait_idle();
        logic [7:0] hi;
        int polls;
        polls = 0;
        host_access(1'b1, xm_bus_pkg::XM_SYS_CTRL, 1'b0, 8'h00, hi);
        while (hi[7]) begin
            polls = polls + 1;
            if (polls > 50) abort_run("memory busy bit never cleared");
            host_access(1'b1, xm_bus_pkg::XM_SYS_CTRL, 1'b0, 8'h00, hi);
        end
    endtask

    initial begin
        logic [15:0] base, incr, w, got, t1, t2;
        logic [7:0] lo_b;
        logic [6:0] m, s, c;
        logic [3:0] mk;
        int n, cyc1, cyc2, lo_ticks;
        mem_rec_t rec;
        void'($urandom(32'h5b48));
        reset = 1'b1;
        bus_cs_n = 1'b1;
        bus_rd_nwr = 1'b1;
        bus_reg_num = '0;
        bus_bytesel = 1'b0;
        bus_data = '0;
        vram_ack = 1'b0;
        vram_data = '0;
        xr_ack = 1'b0;
        xr_data = '0;
        h_blank = 1'b0;
        v_blank = 1'b0;
        intr_status = '0;
        repeat (5) @(posedge clk);
        #5;
        reset = 1'b0;
        n = 4;

        // VRAM writes with increment and nibble mask
        mk = 4'($urandom);
        write_byte(xm_bus_pkg::XM_SYS_CTRL, 1'b1, {4'h0, mk});
        incr = 16'($urandom_range(40, 1));
        base = 16'($urandom);
        write_word(xm_bus_pkg::XM_WR_INCR, incr);
        write_word(xm_bus_pkg::XM_WR_ADDR, base);
        vram_log.delete();
        for (int k = 0; k < n; k++) begin
            w = 16'($urandom);
            write_word((k % 2 == 0) ? xm_bus_pkg::XM_DATA : xm_bus_pkg::XM_DATA_2, w);
            wait_idle();
            if (vram_log.size() != k + 1) abort_run("VRAM write request missing");
            rec = vram_log[k];
            check_word("vram_wr_flag", 16'd1, {15'd0, rec.wr});
            check_word("vram_wr_addr", base + 16'(k) * incr, rec.addr);
            check_word("vram_wr_data", w, rec.data);
            check_word("vram_wr_mask", {12'd0, mk}, {12'd0, rec.mask});
        end
        read_word(xm_bus_pkg::XM_WR_ADDR, got);
        check_word("wr_addr_after", base + 16'(n) * incr, got);

        // VRAM reads, first word fetched by the RD_ADDR write
        incr = 16'($urandom_range(40, 1));
        base = 16'($urandom);
        write_word(xm_bus_pkg::XM_RD_INCR, incr);
        write_word(xm_bus_pkg::XM_RD_ADDR, base);
        wait_idle();
        for (int k = 0; k < n; k++) begin
            read_word(xm_bus_pkg::XM_DATA, got);
            check_word("vram_rd_data", model_word(base + 16'(k) * incr), got);
            wait_idle();
        end
        read_word(xm_bus_pkg::XM_RD_ADDR, got);
        check_word("rd_addr_after", base + 16'(n + 1) * incr, got);

        // XR writes and reads, always +1
        base = 16'($urandom);
        write_word(xm_bus_pkg::XM_WR_XADDR, base);
        xr_log.delete();
        for (int k = 0; k < n; k++) begin
            w = 16'($urandom);
            write_word(xm_bus_pkg::XM_XDATA, w);
            wait_idle();
            if (xr_log.size() != k + 1) abort_run("XR write request missing");
            check_word("xr_wr_flag", 16'd1, {15'd0, xr_log[k].wr});
            check_word("xr_wr_addr", base + 16'(k), xr_log[k].addr);
            check_word("xr_wr_data", w, xr_log[k].data);
        end
        read_word(xm_bus_pkg::XM_WR_XADDR, got);
        check_word("wr_xaddr_after", base + 16'(n), got);
        base = 16'($urandom);
        write_word(xm_bus_pkg::XM_RD_XADDR, base);
        wait_idle();
        for (int k = 0; k < n; k++) begin
            read_word(xm_bus_pkg::XM_XDATA, got);
            check_word("xr_rd_data", model_word(base + 16'(k)), got);
            wait_idle();
        end

        // interrupt mask, status and clear pulse
        m = 7'($urandom);
        s = 7'($urandom);
        intr_status = s;
        write_byte(xm_bus_pkg::XM_INT_CTRL, 1'b0, {1'b0, m});
        read_word(xm_bus_pkg::XM_INT_CTRL, got);
        check_word("int_ctrl_read", {1'b0, m, 1'b0, s}, got);
        check_word("intr_mask_out", {9'd0, m}, {9'd0, intr_mask});
        c = 7'($urandom) | 7'd1;
        clear_count = 0;
        write_byte(xm_bus_pkg::XM_INT_CTRL, 1'b1, {1'b0, c});
        check_word("clear_pulses", 16'd1, 16'(clear_count));
        check_word("clear_value", {9'd0, c}, {9'd0, clear_value});

        // status bits and nibble mask
        h_blank = 1'b1;
        v_blank = 1'b0;
        mk = 4'($urandom);
        write_byte(xm_bus_pkg::XM_SYS_CTRL, 1'b1, {4'h0, mk});
        read_word(xm_bus_pkg::XM_SYS_CTRL, got);
        check_word("sys_ctrl_read", {1'b0, 3'b000, 1'b1, 1'b0, 6'd0, mk}, got);
        h_blank = 1'b0;                             // swap to see each bit on its own
        v_blank = 1'b1;
        read_word(xm_bus_pkg::XM_SYS_CTRL, got);
        check_word("sys_ctrl_vblank", {1'b0, 3'b000, 1'b0, 1'b1, 6'd0, mk}, got);

        // timer rate, C measured between the two high byte reads
        host_access(1'b1, xm_bus_pkg::XM_TIMER, 1'b0, 8'h00, t1[15:8]);
        cyc1 = cycle;
        host_access(1'b1, xm_bus_pkg::XM_TIMER, 1'b1, 8'h00, t1[7:0]);
        repeat (12000) @(posedge clk);
        host_access(1'b1, xm_bus_pkg::XM_TIMER, 1'b0, 8'h00, t2[15:8]);
        cyc2 = cycle;
        host_access(1'b1, xm_bus_pkg::XM_TIMER, 1'b1, 8'h00, t2[7:0]);
        lo_ticks = 2 * (cyc2 - cyc1) / 5025;
        assert ((t2 - t1) >= 16'(lo_ticks) && (t2 - t1) <= 16'(lo_ticks + 1)) else begin
            abort_run($sformatf("error timer_rate: expected %0d or %0d, actual %0d",
                                lo_ticks, lo_ticks + 1, t2 - t1));
        end
        // low byte frozen until the next high byte read
        repeat (6000) @(posedge clk);
        host_access(1'b1, xm_bus_pkg::XM_TIMER, 1'b1, 8'h00, lo_b);
        check_word("timer_latch", {8'd0, t2[7:0]}, {8'd0, lo_b});

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== sim.f ====
xm_bus_pkg.sv
xm_mem_pkg.sv
xm_bus_sync.sv
xm_vram_port.sv
xm_xr_port.sv
xm_timer.sv
xm_sys_regs.sv
xm_reg_interface.sv
tb_xm_sva.sv
tb_xm_reg_interface.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_xm_reg_interface -f sim.f -o tb_sim
./obj_dir/tb_sim
